//--- Bender.yml
package:
  name: mem_subsys

sources:
  - source/mem_pkg.sv
  - source/cache_pkg.sv
  - source/line_ram.sv
  - source/main_mem.sv
  - source/dcache_ctrl.sv
  - source/mem_subsys_top.sv
  - target: test
    files:
      - bench/mem_subsys_chk.sv
      - bench/mem_subsys_tb.sv

//--- bench/mem_subsys_chk.sv
`timescale 1ns/10ps

module mem_subsys_chk (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               cpu_req,
    input  logic                               cpu_we,
    input  logic [mem_pkg::ADDR_W-1:0]         cpu_addr,
    input  logic [mem_pkg::XLEN-1:0]           cpu_wdata,
    input  logic [mem_pkg::XLEN/8-1:0]         cpu_wstrb,
    input  logic [mem_pkg::XLEN-1:0]           cpu_rdata,
    input  logic                               cpu_ack,
    input  logic                               mem_req,
    input  logic                               mem_we,
    input  logic [mem_pkg::MEM_LINE_AW-1:0]    mem_line_addr,
    input  logic                               mem_ack
);
    import mem_pkg::*;
    import cache_pkg::*;

    // Raised by any failing assertion, watched by the testbench
    bit failed = 1'b0;

    // Shadow of every word the core can reach
    logic [XLEN-1:0] shadow [MEM_LINES*LINE_WORDS];

    // Cache contents as implied by completed requests
    logic [CACHE_SETS-1:0] set_valid;
    logic [CACHE_SETS-1:0] set_dirty;
    tag_t                  set_tag [CACHE_SETS];

    // Reset seen at the previous edge
    logic rst_q;
    // Request accepted and not yet acknowledged
    logic pending;

    // Memory transfers seen during the current request
    logic [1:0]             wb_cnt;
    logic [1:0]             rd_cnt;
    logic                   rd_after_wb;
    logic [MEM_LINE_AW-1:0] wb_addr;
    logic [MEM_LINE_AW-1:0] rd_addr;

    tag_t                         req_tag;
    idx_t                         req_idx;
    logic [MEM_LINE_AW+OFS_W-1:0] word_idx;
    logic [MEM_LINE_AW-1:0]       req_line;
    logic [MEM_LINE_AW-1:0]       victim_line;
    logic [XLEN-1:0]              exp_rdata;
    logic                         start;
    logic                         exp_hit;
    logic                         dirty_miss;
    logic                         clean_miss;

    assign req_tag = cpu_addr[TAG_LSB +: TAG_W];
    assign req_idx = cpu_addr[IDX_LSB +: IDX_W];
    assign word_idx = cpu_addr[OFS_LSB +: MEM_LINE_AW+OFS_W];
    assign req_line = {req_tag, req_idx};
    // Line that a dirty miss has to write back
    assign victim_line = {set_tag[req_idx], req_idx};
    assign exp_rdata = shadow[word_idx];

    // Same condition under which the controller takes a request
    assign start = cpu_req && !cpu_ack && !pending;
    assign exp_hit = set_valid[req_idx] && (set_tag[req_idx] == req_tag);
    assign dirty_miss = !exp_hit && set_valid[req_idx] && set_dirty[req_idx];
    assign clean_miss = !exp_hit && !dirty_miss;

    always_ff @(posedge clk) begin
        rst_q <= rst_n;
    end

    // Set state follows each completed request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            set_valid <= '0;
            set_dirty <= '0;
        end else if (cpu_ack) begin
            pending <= 1'b0;
            set_valid[req_idx] <= 1'b1;
            set_tag[req_idx] <= req_tag;
            // Fresh fill is dirty only for a store, a hit store sets it
            if (!exp_hit) begin
                set_dirty[req_idx] <= cpu_we;
            end else if (cpu_we) begin
                set_dirty[req_idx] <= 1'b1;
            end
        end else if (cpu_req) begin
            pending <= 1'b1;
        end
    end

    // Strobed bytes land in the shadow at the store acknowledge
    always_ff @(posedge clk) begin
        if (rst_n && cpu_ack && cpu_we) begin
            for (int b = 0; b < XLEN / 8; b++) begin
                if (cpu_wstrb[b]) begin
                    shadow[word_idx][b*8 +: 8] <= cpu_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Log of line transfers, cleared when a request starts
    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            wb_cnt <= '0;
            rd_cnt <= '0;
            rd_after_wb <= 1'b0;
        end else if (mem_ack) begin
            if (mem_we) begin
                wb_cnt <= wb_cnt + 1'b1;
                wb_addr <= mem_line_addr;
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
                rd_addr <= mem_line_addr;
                rd_after_wb <= (wb_cnt != 0);
            end
        end
    end

    a_reset_low: assert property (@(posedge clk)
        !rst_q |-> !cpu_ack && !mem_req && !mem_ack)
    else begin
        failed = 1'b1;
        $error("Error at %0t: cpu_ack/mem_req/mem_ack expected 0/0/0, got %b/%b/%b",
               $time, $sampled(cpu_ack), $sampled(mem_req), $sampled(mem_ack));
    end

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ack && !cpu_we |-> cpu_rdata == exp_rdata)
    else begin
        failed = 1'b1;
        $error("Error at %0t: cpu_rdata expected %08h, got %08h",
               $time, $sampled(exp_rdata), $sampled(cpu_rdata));
    end

    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start && exp_hit |=> (!cpu_ack && !mem_req) ##1 (cpu_ack && !mem_req))
    else begin
        failed = 1'b1;
        $error("Error at %0t: hit on line %h was not acknowledged 2 cycles after it started",
               $time, $sampled(req_line));
    end

    // Five sampled cycles of waiting, one of acknowledge, then low again
    a_mem_timing: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> (mem_req && !mem_ack) [*5] ##1 (mem_req && mem_ack) ##1 !mem_ack)
    else begin
        failed = 1'b1;
        $error("Error at %0t: mem_ack did not pulse 5 cycles after mem_req rose", $time);
    end

    a_mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && $past(mem_req) && !$past(mem_ack)
            |-> $stable(mem_we) && $stable(mem_line_addr))
    else begin
        failed = 1'b1;
        $error("Error at %0t: mem_line_addr expected %h, got %h while mem_req waited",
               $time, $past(mem_line_addr), $sampled(mem_line_addr));
    end

    a_dirty_miss: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ack && dirty_miss |-> (wb_cnt == 2'd1) && (rd_cnt == 2'd1) && rd_after_wb
            && (wb_addr == victim_line) && (rd_addr == req_line))
    else begin
        failed = 1'b1;
        $error("Error at %0t: miss on line %h did not write back line %h before the refill",
               $time, $sampled(req_line), $sampled(victim_line));
    end

    a_clean_miss: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ack && clean_miss |-> (wb_cnt == 2'd0) && (rd_cnt == 2'd1)
            && (rd_addr == req_line))
    else begin
        failed = 1'b1;
        $error("Error at %0t: clean miss on line %h did not issue one read only",
               $time, $sampled(req_line));
    end

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ack |-> cpu_req ##1 !cpu_ack)
    else begin
        failed = 1'b1;
        $error("Error at %0t: cpu_ack was high without cpu_req or for two cycles", $time);
    end

endmodule

bind mem_subsys_top mem_subsys_chk chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_req       (cpu_req),
    .cpu_we        (cpu_we),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_wstrb     (cpu_wstrb),
    .cpu_rdata     (cpu_rdata),
    .cpu_ack       (cpu_ack),
    .mem_req       (mem_req),
    .mem_we        (mem_we),
    .mem_line_addr (mem_line_addr),
    .mem_ack       (mem_ack)
);

//--- bench/mem_subsys_tb.sv
`timescale 1ns/10ps

module mem_subsys_tb;
    import mem_pkg::*;
    import cache_pkg::*;

    // Pool fill plus five directed requests, then the random run
    localparam int NUM_PROLOGUE = 3 * 4 * 4 + 5;
    localparam int NUM_RANDOM = 300;
    localparam int CYCLES_PER_REQ = 20;
    localparam int TIMEOUT_CYCLES = 10 + (NUM_PROLOGUE + NUM_RANDOM) * CYCLES_PER_REQ;

    logic              clk;
    logic              rst_n;
    logic              cpu_req;
    logic              cpu_we;
    logic [ADDR_W-1:0] cpu_addr;
    logic [XLEN-1:0]   cpu_wdata;
    logic [XLEN/8-1:0] cpu_wstrb;
    logic [XLEN-1:0]   cpu_rdata;
    logic              cpu_ack;

    logic [15:0] lfsr_q;
    int          cycle_cnt = 0;

    // Three tags over four sets keep conflicts frequent
    tag_t pool_tag [3] = '{4'h2, 4'h7, 4'hD};
    idx_t pool_idx [4] = '{4'h1, 4'h4, 4'h9, 4'hE};

    mem_subsys_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val = {val[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input tag_t t, input idx_t i,
                                                    input ofs_t o);
        logic [ADDR_W-1:0] a;
        a = '0;
        a[TAG_LSB +: TAG_W] = t;
        a[IDX_LSB +: IDX_W] = i;
        a[OFS_LSB +: OFS_W] = o;
        return a;
    endfunction

    // Hold one request until acknowledged, return in the cycle after
    task automatic run_request(input logic we, input logic [ADDR_W-1:0] addr,
                               input logic [XLEN-1:0] wdata, input logic [XLEN/8-1:0] wstrb);
        cpu_req = 1'b1;
        cpu_we = we;
        cpu_addr = addr;
        cpu_wdata = wdata;
        cpu_wstrb = wstrb;
        do begin
            @(posedge clk);
            #1;
        end while (!cpu_ack);
        @(posedge clk);
        #1;
    endtask

    // First failing assertion or a stuck run ends the simulation
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (UUT.chk.failed) begin
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first failing check");
        end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: requests did not complete");
            $display("TEST FAIL");
            $fatal(1, "Cycle limit reached");
        end
    end

    initial begin
        logic [31:0]       r;
        logic [31:0]       d;
        logic [ADDR_W-1:0] a;
        logic [XLEN/8-1:0] strb;
        lfsr_q = 16'd18;
        rst_n = 1'b0;
        cpu_req = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Full-word stores over the pool, later tags evict dirty lines
        for (int ti = 0; ti < 3; ti++) begin
            for (int si = 0; si < 4; si++) begin
                for (int oi = 0; oi < 4; oi++) begin
                    draw_bits(32, d);
                    run_request(1'b1, make_addr(pool_tag[ti], pool_idx[si], ofs_t'(oi)),
                                d, 4'hF);
                end
            end
        end

        // Data back from memory, then hits and a partial store
        a = make_addr(pool_tag[0], pool_idx[0], 2'd1);
        run_request(1'b0, a, '0, '0);
        run_request(1'b0, a, '0, '0);
        run_request(1'b1, a, 32'hA5C3_0F96, 4'b0101);
        run_request(1'b0, a, '0, '0);
        // Evicts the line that was just made dirty
        run_request(1'b0, make_addr(pool_tag[1], pool_idx[0], 2'd3), '0, '0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            draw_bits(2, r);
            a = make_addr(pool_tag[r % 3], 4'h0, 2'd0);
            draw_bits(2, r);
            a[IDX_LSB +: IDX_W] = pool_idx[r[1:0]];
            draw_bits(OFS_W, r);
            a[OFS_LSB +: OFS_W] = r[OFS_W-1:0];
            draw_bits(32, d);
            draw_bits(4, r);
            strb = r[3:0];
            // One bit picks store or load
            draw_bits(1, r);
            run_request(r[0], a, d, strb);
            // Sometimes leave the port idle for a cycle
            draw_bits(1, r);
            if (r[0]) begin
                cpu_req = 1'b0;
                @(posedge clk);
                #1;
            end
        end

        cpu_req = 1'b0;
        repeat (3) @(posedge clk);
        if (UUT.chk.failed) begin
            $display("TEST FAIL");
            $fatal(1, "Assertion failures were reported");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- build.f
source/mem_pkg.sv
source/cache_pkg.sv
source/line_ram.sv
source/main_mem.sv
source/dcache_ctrl.sv
source/mem_subsys_top.sv
bench/mem_subsys_chk.sv
bench/mem_subsys_tb.sv

//--- source/cache_pkg.sv
package cache_pkg;

    // Direct-mapped, one line per set
    localparam int CACHE_SETS = 16;

    // Address field widths
    localparam int IDX_W = $clog2(CACHE_SETS);
    localparam int TAG_W = mem_pkg::MEM_LINE_AW - IDX_W;
    localparam int OFS_W = $clog2(mem_pkg::LINE_WORDS);

    // Field positions in the byte address
    // Bits 1..0 select a byte inside the word and are not used here
    localparam int OFS_LSB = 2;
    localparam int IDX_LSB = OFS_LSB + OFS_W;
    localparam int TAG_LSB = IDX_LSB + IDX_W;

    // Stored tag
    typedef logic [TAG_W-1:0] tag_t;

    // Set index
    typedef logic [IDX_W-1:0] idx_t;

    // Word inside a line
    typedef logic [OFS_W-1:0] ofs_t;

endpackage

//--- source/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                               clk,
    input  logic                               rst_n,

    // Core side
    input  logic                               cpu_req,
    input  logic                               cpu_we,
    input  logic [mem_pkg::ADDR_W-1:0]         cpu_addr,
    input  logic [mem_pkg::XLEN-1:0]           cpu_wdata,
    input  logic [mem_pkg::XLEN/8-1:0]         cpu_wstrb,
    output logic [mem_pkg::XLEN-1:0]           cpu_rdata,
    output logic                               cpu_ack,

    // Tag array
    output logic                               tag_rd_en,
    output cache_pkg::idx_t                    tag_rd_idx,
    input  cache_pkg::tag_t                    tag_rd_data,
    output logic                               tag_wr_en,
    output cache_pkg::idx_t                    tag_wr_idx,
    output cache_pkg::tag_t                    tag_wr_data,

    // Data array
    output logic                               data_rd_en,
    output cache_pkg::idx_t                    data_rd_idx,
    input  mem_pkg::line_t                     data_rd_data,
    output logic                               data_wr_en,
    output cache_pkg::idx_t                    data_wr_idx,
    output mem_pkg::line_t                     data_wr_data,

    // Main memory side
    output logic                               mem_req,
    output logic                               mem_we,
    output logic [mem_pkg::MEM_LINE_AW-1:0]    mem_line_addr,
    output mem_pkg::line_t                     mem_wline,
    input  mem_pkg::line_t                     mem_rline,
    input  logic                               mem_ack
);
    import mem_pkg::*;
    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_refill,
        st_fill
    } state_t;

    state_t state;

    // Per-set status bits
    logic [CACHE_SETS-1:0] valid_q;
    logic [CACHE_SETS-1:0] dirty_q;

    // Line captured from the memory during refill
    line_t fill_line;

    // Address fields of the pending request
    tag_t cpu_tag;
    idx_t cpu_idx;
    ofs_t cpu_ofs;

    logic  accept;
    logic  hit;
    logic  done;
    line_t base_line;
    line_t store_line;

    // Merge the strobed bytes of one word into a line
    function automatic line_t merge_word(
        input line_t                line,
        input ofs_t                 ofs,
        input logic [XLEN-1:0]      wdata,
        input logic [XLEN/8-1:0]    wstrb
    );
        line_t result;
        result = line;
        for (int b = 0; b < XLEN / 8; b++) begin
            if (wstrb[b]) begin
                result[ofs*XLEN + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // Fields are stable while cpu_req waits for cpu_ack
    assign cpu_tag = cpu_addr[TAG_LSB +: TAG_W];
    assign cpu_idx = cpu_addr[IDX_LSB +: IDX_W];
    assign cpu_ofs = cpu_addr[OFS_LSB +: OFS_W];

    // No new request in the acknowledge cycle
    assign accept = (state == st_idle) && cpu_req && !cpu_ack;

    // Compare against the tag read at the accept edge
    assign hit = valid_q[cpu_idx] && (tag_rd_data == cpu_tag);

    // Request completes at this edge
    assign done = ((state == st_lookup) && hit) || (state == st_fill);

    // Hit line or refilled line, then the store merged on top
    assign base_line = (state == st_fill) ? fill_line : data_rd_data;
    assign store_line = merge_word(base_line, cpu_ofs, cpu_wdata, cpu_wstrb);

    // Both arrays are read together at the accept edge
    assign tag_rd_en = accept;
    assign tag_rd_idx = cpu_idx;
    assign data_rd_en = accept;
    assign data_rd_idx = cpu_idx;

    // Tag written only on a fill
    assign tag_wr_en = (state == st_fill);
    assign tag_wr_idx = cpu_idx;
    assign tag_wr_data = cpu_tag;

    // Data written on a store hit or on a fill
    assign data_wr_en = ((state == st_lookup) && hit && cpu_we) || (state == st_fill);
    assign data_wr_idx = cpu_idx;
    assign data_wr_data = cpu_we ? store_line : base_line;

    // Victim address comes from the stored tag, refill from the request
    assign mem_we = (state == st_write_back);
    assign mem_line_addr = (state == st_write_back) ? {tag_rd_data, cpu_idx}
                                                    : {cpu_tag, cpu_idx};
    // Array read data is held through the write-back
    assign mem_wline = data_rd_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            cpu_ack <= 1'b0;
            mem_req <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            cpu_ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        cpu_ack <= 1'b1;
                        state <= st_idle;
                        if (cpu_we) begin
                            dirty_q[cpu_idx] <= 1'b1;
                        end
                    end else begin
                        // Memory request goes out straight from lookup
                        mem_req <= 1'b1;
                        if (valid_q[cpu_idx] && dirty_q[cpu_idx]) begin
                            state <= st_write_back;
                        end else begin
                            state <= st_refill;
                        end
                    end
                end
                st_write_back: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state <= st_refill;
                    end
                end
                st_refill: begin
                    // After a write-back the request is low for one cycle
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state <= st_fill;
                    end else begin
                        mem_req <= 1'b1;
                    end
                end
                st_fill: begin
                    valid_q[cpu_idx] <= 1'b1;
                    dirty_q[cpu_idx] <= cpu_we;
                    cpu_ack <= 1'b1;
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Refill line is only valid in the acknowledge cycle
    always_ff @(posedge clk) begin
        if ((state == st_refill) && mem_ack) begin
            fill_line <= mem_rline;
        end
    end

    // Load data, valid while cpu_ack is high
    always_ff @(posedge clk) begin
        if (done) begin
            cpu_rdata <= base_line[cpu_ofs*XLEN +: XLEN];
        end
    end

endmodule

//--- source/line_ram.sv
`timescale 1ns/10ps

module line_ram #(
    parameter type entry_t = logic
) (
    input  logic              clk,
    input  logic              rd_en,
    input  cache_pkg::idx_t   rd_idx,
    output entry_t            rd_data,
    input  logic              wr_en,
    input  cache_pkg::idx_t   wr_idx,
    input  entry_t            wr_data
);
    import cache_pkg::*;

    // One entry per set
    entry_t mem_array [CACHE_SETS];

    // Registered read
    // Output holds its value while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem_array[rd_idx];
        end
    end

    // Write port
    // Same-index read in the same cycle still sees the old entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_array[wr_idx] <= wr_data;
        end
    end

endmodule

//--- source/main_mem.sv
`timescale 1ns/10ps

module main_mem (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               mem_req,
    input  logic                               mem_we,
    input  logic [mem_pkg::MEM_LINE_AW-1:0]    mem_line_addr,
    input  mem_pkg::line_t                     mem_wline,
    output mem_pkg::line_t                     mem_rline,
    output logic                               mem_ack
);
    import mem_pkg::*;

    // Line-wide storage, contents unknown after power-up
    line_t mem_array [MEM_LINES];

    // Counts edges with a pending request
    logic [DELAY_W-1:0] delay_cnt;

    // High in the one cycle in which the request is served
    logic serve;

    // Counter saturates so a long-held request never wraps it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            delay_cnt <= '0;
        end else if (!mem_req) begin
            delay_cnt <= '0;
        end else if (~&delay_cnt) begin
            delay_cnt <= delay_cnt + 1'b1;
        end
    end

    // Served once the delay has elapsed and no acknowledge is out
    assign serve = mem_req && !mem_ack && (delay_cnt == DELAY_W'(MEM_DELAY));

    // Acknowledge is a single-cycle pulse after the access
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= serve;
        end
    end

    // Whole-line write
    always_ff @(posedge clk) begin
        if (serve && mem_we) begin
            mem_array[mem_line_addr] <= mem_wline;
        end
    end

    // Whole-line read
    // Read line is valid while mem_ack is high, held afterwards
    always_ff @(posedge clk) begin
        if (serve && !mem_we) begin
            mem_rline <= mem_array[mem_line_addr];
        end
    end

endmodule

//--- source/mem_pkg.sv
package mem_pkg;

    // Core address width, only the low bits reach the cache
    localparam int ADDR_W = 32;

    // Core data word
    localparam int XLEN = 32;

    // Line geometry
    localparam int LINE_WORDS = 4;
    localparam int LINE_BITS = XLEN * LINE_WORDS;

    // Main memory depth in lines
    localparam int MEM_LINES = 256;
    localparam int MEM_LINE_AW = $clog2(MEM_LINES);

    // Counter value at which the memory serves a request
    localparam int MEM_DELAY = 4;
    // Counter must reach MEM_DELAY plus a little headroom before saturating
    localparam int DELAY_W = $clog2(MEM_DELAY + 2);

    // One whole line on the memory bus
    typedef logic [LINE_BITS-1:0] line_t;

endpackage

//--- source/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cpu_req,
    input  logic                          cpu_we,
    input  logic [mem_pkg::ADDR_W-1:0]    cpu_addr,
    input  logic [mem_pkg::XLEN-1:0]      cpu_wdata,
    input  logic [mem_pkg::XLEN/8-1:0]    cpu_wstrb,
    output logic [mem_pkg::XLEN-1:0]      cpu_rdata,
    output logic                          cpu_ack
);
    import mem_pkg::*;
    import cache_pkg::*;

    // Tag array wires
    logic tag_rd_en;
    idx_t tag_rd_idx;
    tag_t tag_rd_data;
    logic tag_wr_en;
    idx_t tag_wr_idx;
    tag_t tag_wr_data;

    // Data array wires
    logic  data_rd_en;
    idx_t  data_rd_idx;
    line_t data_rd_data;
    logic  data_wr_en;
    idx_t  data_wr_idx;
    line_t data_wr_data;

    // Controller to main memory
    logic                   mem_req;
    logic                   mem_we;
    logic [MEM_LINE_AW-1:0] mem_line_addr;
    line_t                  mem_wline;
    line_t                  mem_rline;
    logic                   mem_ack;

    dcache_ctrl u_ctrl (.*);

    // Tags, one per set
    line_ram #(
        .entry_t(tag_t)
    ) tag_ram (
        .clk     (clk),
        .rd_en   (tag_rd_en),
        .rd_idx  (tag_rd_idx),
        .rd_data (tag_rd_data),
        .wr_en   (tag_wr_en),
        .wr_idx  (tag_wr_idx),
        .wr_data (tag_wr_data)
    );

    // Lines, one per set
    line_ram #(
        .entry_t(line_t)
    ) data_ram (
        .clk     (clk),
        .rd_en   (data_rd_en),
        .rd_idx  (data_rd_idx),
        .rd_data (data_rd_data),
        .wr_en   (data_wr_en),
        .wr_idx  (data_wr_idx),
        .wr_data (data_wr_data)
    );

    main_mem u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req       (mem_req),
        .mem_we        (mem_we),
        .mem_line_addr (mem_line_addr),
        .mem_wline     (mem_wline),
        .mem_rline     (mem_rline),
        .mem_ack       (mem_ack)
    );

endmodule
